// ==== hdl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // Word geometry. The split rules assume four byte lanes.
    localparam int DATA_W = 32;
    localparam int LANES = 4;
    localparam int ADDR_W = 16;

    typedef enum logic [1:0] {
        ACC_8  = 2'b00,
        ACC_16 = 2'b01,
        ACC_32 = 2'b10
    } acc_width_e;

    // Write data sits in the low bytes of wdata.
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;
        acc_width_e        width;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    // Access sequencer states.
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        HI_ADDR = 3'd1,
        HI_DATA = 3'd2,
        LO_ADDR = 3'd3,
        LO_DATA = 3'd4,
        DONE    = 3'd5
    } seq_state_e;

endpackage

`default_nettype wire

// ==== hdl/byte_lane.sv ====
`default_nettype none

module byte_lane #(
    parameter int DEPTH_WORDS = 256
) (
    input  wire logic                             clk,
    input  wire logic [$clog2(DEPTH_WORDS)-1:0]   addr,
    input  wire logic                             we,
    input  wire logic [7:0]                       wdata,
    output logic [7:0]                            rdata
);

    logic [7:0] mem [DEPTH_WORDS];

    // Read returns the old contents on a same-cycle write.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== hdl/mem_client_mux.sv ====
`default_nettype none

module mem_client_mux #(
    parameter int CLIENT_CNT = 2
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic [CLIENT_CNT-1:0]        req,
    input  wire mem_pkg::mem_req_t            client_req [CLIENT_CNT],
    input  wire logic                         seq_ready,
    input  wire logic [mem_pkg::DATA_W-1:0]   seq_rdata,
    output logic                              sel_valid,
    output mem_pkg::mem_req_t                 sel_req,
    output logic [CLIENT_CNT-1:0]             ready,
    output logic [mem_pkg::DATA_W-1:0]        rdata [CLIENT_CNT]
);

    localparam int IDX_W = (CLIENT_CNT > 1) ? $clog2(CLIENT_CNT) : 1;

    logic [CLIENT_CNT-1:0] grant;
    logic                  held;
    logic [IDX_W-1:0]      last;
    logic [IDX_W-1:0]      pick;
    logic                  pick_valid;

    // Next requester after the last one served, searching round-robin.
    always_comb begin
        int idx;
        pick = last;
        pick_valid = 1'b0;
        for (int k = CLIENT_CNT; k >= 1; k--) begin
            idx = (int'(last) + k) % CLIENT_CNT;
            if (req[idx]) begin
                pick = IDX_W'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= '0;
            held <= 1'b0;
            last <= IDX_W'(CLIENT_CNT - 1);
        end else if (!held) begin
            if (pick_valid) begin
                grant <= CLIENT_CNT'(1) << pick;
                held <= 1'b1;
                last <= pick;
            end
        end else if (!(|(req & grant))) begin
            // Granted client dropped req, so the access is complete.
            held <= 1'b0;
        end
    end

    assign sel_valid = held && (|(req & grant));
    assign sel_req = client_req[last];

    // Completion goes back to the granted client only.
    always_comb begin
        for (int i = 0; i < CLIENT_CNT; i++) begin
            ready[i] = held & grant[i] & seq_ready;
            rdata[i] = (held && grant[i]) ? seq_rdata : '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_if.sv ====
`default_nettype none

module mem_if #(
    parameter int DEPTH_WORDS = 256
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          sel_valid,
    input  wire mem_pkg::mem_req_t             sel_req,
    output logic                               seq_ready,
    output logic [mem_pkg::DATA_W-1:0]         seq_rdata,
    output logic [$clog2(DEPTH_WORDS)-1:0]     lane_addr,
    output logic [mem_pkg::LANES-1:0]          lane_we,
    output logic [mem_pkg::DATA_W-1:0]         lane_wdata,
    input  wire logic [mem_pkg::DATA_W-1:0]    lane_rdata
);

    localparam int AW = $clog2(DEPTH_WORDS);
    localparam int OFF_W = $clog2(mem_pkg::LANES);
    localparam int WORD_W = mem_pkg::ADDR_W - OFF_W;

    mem_pkg::seq_state_e state;

    logic [OFF_W-1:0]            req_off;
    logic [WORD_W-1:0]           req_word;
    logic [OFF_W-1:0]            off_lo;
    logic [OFF_W-1:0]            off_hi;
    logic [AW-1:0]               word_lo;
    logic [AW-1:0]               word_hi;
    logic                        single_pass;
    logic [mem_pkg::LANES-1:0]   be;
    logic [mem_pkg::DATA_W-1:0]  width_mask;
    logic [mem_pkg::DATA_W-1:0]  hi_data;
    logic [mem_pkg::DATA_W-1:0]  rdata_q;

    assign req_off = sel_req.addr[OFF_W-1:0];
    assign req_word = sel_req.addr[mem_pkg::ADDR_W-1:OFF_W];

    // Word addresses wrap at the memory depth.
    assign word_lo = AW'(req_word % DEPTH_WORDS);
    assign word_hi = (word_lo == AW'(DEPTH_WORDS - 1)) ? '0 : word_lo + 1'b1;

    // Upper pass shifts by the complement of the offset.
    assign off_hi = ~off_lo + 1'b1;

    always_comb begin
        case (sel_req.width)
            mem_pkg::ACC_8:  be = 4'b0001;
            mem_pkg::ACC_16: be = 4'b0011;
            default:         be = 4'b1111;
        endcase
    end

    always_comb begin
        for (int k = 0; k < mem_pkg::LANES; k++) begin
            width_mask[8*k +: 8] = {8{be[k]}};
        end
    end

    // One pass when every byte falls inside the addressed word.
    always_comb begin
        case (sel_req.width)
            mem_pkg::ACC_8:  single_pass = 1'b1;
            mem_pkg::ACC_16: single_pass = (req_off != 2'd3);
            default:         single_pass = (req_off == '0);
        endcase
    end

    // Lane address, write data and enables for the current pass.
    always_comb begin
        lane_addr = word_lo;
        lane_we = '0;
        lane_wdata = sel_req.wdata << {off_lo, 3'b000};
        case (state)
            mem_pkg::HI_ADDR: begin
                lane_addr = word_hi;
                lane_wdata = sel_req.wdata >> {off_hi, 3'b000};
                if (sel_req.we) begin
                    lane_we = be >> off_hi;
                end
            end
            mem_pkg::HI_DATA: begin
                lane_addr = word_hi;
                lane_wdata = sel_req.wdata >> {off_hi, 3'b000};
            end
            mem_pkg::LO_ADDR: begin
                if (sel_req.we) begin
                    lane_we = be << off_lo;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_pkg::IDLE;
            off_lo <= '0;
        end else begin
            case (state)
                mem_pkg::IDLE: begin
                    if (sel_valid) begin
                        off_lo <= req_off;
                        state <= single_pass ? mem_pkg::LO_ADDR : mem_pkg::HI_ADDR;
                    end
                end
                mem_pkg::HI_ADDR: state <= mem_pkg::HI_DATA;
                mem_pkg::HI_DATA: state <= mem_pkg::LO_ADDR;
                mem_pkg::LO_ADDR: state <= mem_pkg::LO_DATA;
                mem_pkg::LO_DATA: state <= mem_pkg::DONE;
                mem_pkg::DONE: begin
                    if (!sel_valid) begin
                        state <= mem_pkg::IDLE;
                    end
                end
                default: state <= mem_pkg::IDLE;
            endcase
        end
    end

    // Read merge. Upper bytes land above the lower ones, then mask to width.
    always_ff @(posedge clk) begin
        case (state)
            mem_pkg::IDLE: hi_data <= '0;
            mem_pkg::HI_DATA: hi_data <= lane_rdata << {off_hi, 3'b000};
            mem_pkg::LO_DATA: begin
                rdata_q <= (hi_data | (lane_rdata >> {off_lo, 3'b000})) & width_mask;
            end
            default: begin
            end
        endcase
    end

    assign seq_ready = (state == mem_pkg::DONE) && sel_valid;
    assign seq_rdata = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/mem_subsys.sv ====
`default_nettype none

module mem_subsys #(
    parameter int CLIENT_CNT = 2,
    parameter int DEPTH_WORDS = 256
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic [CLIENT_CNT-1:0]        req,
    input  wire mem_pkg::mem_req_t            client_req [CLIENT_CNT],
    output logic [CLIENT_CNT-1:0]             ready,
    output logic [mem_pkg::DATA_W-1:0]        rdata [CLIENT_CNT]
);

    logic                              sel_valid;
    mem_pkg::mem_req_t                 sel_req;
    logic                              seq_ready;
    logic [mem_pkg::DATA_W-1:0]        seq_rdata;
    logic [$clog2(DEPTH_WORDS)-1:0]    lane_addr;
    logic [mem_pkg::LANES-1:0]         lane_we;
    logic [mem_pkg::DATA_W-1:0]        lane_wdata;
    logic [mem_pkg::DATA_W-1:0]        lane_rdata;

    mem_client_mux #(
        .CLIENT_CNT(CLIENT_CNT)
    ) u_mux (
        .clk(clk),
        .rst(rst),
        .req(req),
        .client_req(client_req),
        .seq_ready(seq_ready),
        .seq_rdata(seq_rdata),
        .sel_valid(sel_valid),
        .sel_req(sel_req),
        .ready(ready),
        .rdata(rdata)
    );

    mem_if #(
        .DEPTH_WORDS(DEPTH_WORDS)
    ) u_seq (
        .clk(clk),
        .rst(rst),
        .sel_valid(sel_valid),
        .sel_req(sel_req),
        .seq_ready(seq_ready),
        .seq_rdata(seq_rdata),
        .lane_addr(lane_addr),
        .lane_we(lane_we),
        .lane_wdata(lane_wdata),
        .lane_rdata(lane_rdata)
    );

    // One lane per byte position of the word.
    for (genvar k = 0; k < mem_pkg::LANES; k++) begin : g_lane
        byte_lane #(
            .DEPTH_WORDS(DEPTH_WORDS)
        ) u_lane (
            .clk(clk),
            .addr(lane_addr),
            .we(lane_we[k]),
            .wdata(lane_wdata[8*k +: 8]),
            .rdata(lane_rdata[8*k +: 8])
        );
    end

endmodule

`default_nettype wire

// ==== verif/mem_subsys_tb.sv ====
`default_nettype none

module mem_subsys_tb;

    localparam int DEPTH = 256;
    localparam int BYTES = DEPTH * mem_pkg::LANES;
    localparam int TIMEOUT = 50;

    logic                        clk;
    logic                        rst;
    logic [1:0]                  req;
    mem_pkg::mem_req_t           client_req [2];
    logic [1:0]                  ready;
    logic [mem_pkg::DATA_W-1:0]  rdata [2];

    logic [7:0]                  model [BYTES];
    logic [mem_pkg::DATA_W-1:0]  exp_rdata [2];
    logic [1:0]                  exp_check;
    logic [1:0]                  pending;
    logic [1:0]                  ready_q;
    int                          last_served;
    logic                        check_alt;

    mem_subsys #(
        .CLIENT_CNT(2),
        .DEPTH_WORDS(DEPTH)
    ) uut (
        .clk(clk),
        .rst(rst),
        .req(req),
        .client_req(client_req),
        .ready(ready),
        .rdata(rdata)
    );

    always #4 clk = ~clk;

    task automatic stop_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic int width_bytes(mem_pkg::acc_width_e w);
        case (w)
            mem_pkg::ACC_8:  return 1;
            mem_pkg::ACC_16: return 2;
            default:         return 4;
        endcase
    endfunction

    // Bytes follow each other linearly and wrap at the end of the memory.
    function automatic logic [31:0] expected_read(logic [mem_pkg::ADDR_W-1:0] addr,
                                                  mem_pkg::acc_width_e w);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < width_bytes(w); b++) begin
            v[8*b +: 8] = model[(int'(addr) + b) % BYTES];
        end
        return v;
    endfunction

    // An access that runs past the end of its word takes two passes.
    function automatic int expected_latency(mem_pkg::mem_req_t r);
        if (int'(r.addr[1:0]) + width_bytes(r.width) > mem_pkg::LANES) begin
            return 6;
        end
        return 4;
    endfunction

    function automatic logic [31:0] fill_word(int w);
        logic [7:0] a;
        a = 8'(w);
        return {a ^ 8'hc3, a + 8'h40, ~a, a};
    endfunction

    function automatic mem_pkg::mem_req_t make_req(int addr, logic we,
                                                   mem_pkg::acc_width_e w, logic [31:0] d);
        mem_pkg::mem_req_t r;
        r.addr = 16'(addr);
        r.we = we;
        r.width = w;
        r.wdata = d;
        return r;
    endfunction

    task automatic write_model(mem_pkg::mem_req_t r);
        for (int b = 0; b < width_bytes(r.width); b++) begin
            model[(int'(r.addr) + b) % BYTES] = r.wdata[8*b +: 8];
        end
    endtask

    task automatic wait_ready(input int c, output int cycles);
        cycles = 0;
        @(negedge clk);
        while (ready[c] !== 1'b1) begin
            if (cycles >= TIMEOUT) begin
                $display("Client %0d got no ready within %0d cycles at %0t", c, TIMEOUT, $time);
                stop_run();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // One full handshake. A negative lat skips the latency check.
    task automatic do_access(int c, mem_pkg::mem_req_t r, int lat, int hold);
        int cycles;
        @(posedge clk);
        exp_rdata[c] = expected_read(r.addr, r.width);
        exp_check[c] = !r.we;
        if (r.we) write_model(r);
        pending[c] = 1'b1;
        req[c] <= 1'b1;
        client_req[c] <= r;
        wait_ready(c, cycles);
        if (lat >= 0) begin
            assert (cycles == lat) else begin
                $display("ERR %0t ready[%0d] latency expected %0d got %0d", $time, c, lat, cycles);
                stop_run();
            end
        end
        // Client back-pressures by keeping req high.
        for (int h = 0; h < hold; h++) begin
            @(negedge clk);
            assert (ready[c] === 1'b1 && ready[1-c] === 1'b0) else begin
                $display("ERR %0t ready expected %b got %b", $time, 2'b01 << c, ready);
                stop_run();
            end
        end
        @(posedge clk);
        req[c] <= 1'b0;
        pending[c] = 1'b0;
        exp_check[c] = 1'b0;
    endtask

    task automatic random_traffic(int c, int n);
        mem_pkg::mem_req_t r;
        int word;
        for (int k = 0; k < n; k++) begin
            // Disjoint word ranges keep the two clients independent.
            word = (c == 0) ? 2 + $urandom % 124 : 128 + $urandom % 128;
            r.addr = {6'($urandom), 8'(word), 2'($urandom)};
            r.we = 1'($urandom);
            r.width = mem_pkg::acc_width_e'($urandom % 3);
            r.wdata = $urandom;
            do_access(c, r, -1, $urandom % 2);
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            assert (!(ready[0] === 1'b1 && ready[1] === 1'b1)) else begin
                $display("Both clients saw ready at once at %0t", $time);
                stop_run();
            end
            for (int i = 0; i < 2; i++) begin
                if (ready[i] === 1'b1) begin
                    assert (pending[i]) else begin
                        $display("Client %0d saw ready with no request at %0t", i, $time);
                        stop_run();
                    end
                    if (exp_check[i]) begin
                        assert (rdata[i] === exp_rdata[i]) else begin
                            $display("ERR %0t rdata[%0d] expected %08h got %08h",
                                     $time, i, exp_rdata[i], rdata[i]);
                            stop_run();
                        end
                    end
                    if (!ready_q[i]) begin
                        assert (!check_alt || i != last_served) else begin
                            $display("Client %0d was served twice in a row at %0t", i, $time);
                            stop_run();
                        end
                        last_served = i;
                    end
                end
            end
        end
        ready_q = ready;
    end

    initial begin
        mem_pkg::mem_req_t r;
        int a;
        int cycles;
        clk = 1'b0;
        rst = 1'b1;
        req = '0;
        client_req[0] = '0;
        client_req[1] = '0;
        exp_rdata[0] = '0;
        exp_rdata[1] = '0;
        exp_check = '0;
        pending = '0;
        ready_q = '0;
        last_served = -1;
        check_alt = 1'b0;
        void'($urandom(32'h8425));

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (10) begin
            @(negedge clk);
            assert (ready === 2'b00) else begin
                $display("ERR %0t ready expected 00 got %b", $time, ready);
                stop_run();
            end
        end

        // Aligned words over the whole memory, then read back.
        for (int w = 0; w < DEPTH; w++) begin
            do_access(0, make_req(w * 4, 1'b1, mem_pkg::ACC_32, fill_word(w)), 4, 0);
        end
        for (int w = 0; w < DEPTH; w++) begin
            do_access(w % 2, make_req(w * 4, 1'b0, mem_pkg::ACC_32, '0), 4, 0);
        end

        // Narrow writes, then reads of every width around them.
        for (int off = 0; off < 4; off++) begin
            do_access(0, make_req(80 + off, 1'b1, mem_pkg::ACC_8, $urandom), 4, 0);
        end
        for (int off = 0; off < 3; off++) begin
            do_access(1, make_req(84 + off, 1'b1, mem_pkg::ACC_16, $urandom), 4, 0);
        end
        for (a = 76; a < 96; a++) begin
            for (int w = 0; w < 3; w++) begin
                r = make_req(a, 1'b0, mem_pkg::acc_width_e'(w), '0);
                do_access(a % 2, r, expected_latency(r), 0);
            end
        end

        // Split accesses, including the wrap from the last word.
        for (int k = 0; k < 6; k++) begin
            a = (k < 3) ? 41 + k : 1018 + k;
            r = make_req(a, 1'b1, mem_pkg::ACC_32, $urandom);
            do_access(0, r, 6, 0);
            r.we = 1'b0;
            do_access(1, r, 6, 0);
        end
        for (int k = 0; k < 2; k++) begin
            a = (k == 0) ? 43 : 1023;
            r = make_req(a, 1'b1, mem_pkg::ACC_16, $urandom);
            do_access(1, r, 6, 0);
            r.we = 1'b0;
            do_access(0, r, 6, 0);
        end
        do_access(0, make_req(16'hfffd, 1'b0, mem_pkg::ACC_32, '0), 6, 0);

        // Both clients at once.
        last_served = -1;
        check_alt = 1'b1;
        fork
            for (int k = 0; k < 6; k++) begin
                do_access(0, make_req(4 * (50 + k % 3), k < 3, mem_pkg::ACC_32, $urandom), -1, 0);
            end
            for (int k = 0; k < 6; k++) begin
                do_access(1, make_req(4 * (150 + k % 3) + 1, k < 3, mem_pkg::ACC_16, $urandom),
                          -1, 0);
            end
        join
        check_alt = 1'b0;

        // Back-pressure while the other client waits.
        fork
            do_access(0, make_req(4 * 60 + 1, 1'b0, mem_pkg::ACC_32, '0), 6, 8);
            begin
                wait_ready(0, cycles);
                do_access(1, make_req(4 * 160, 1'b0, mem_pkg::ACC_16, '0), -1, 0);
            end
        join

        fork
            random_traffic(0, 100);
            random_traffic(1, 100);
        join

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_subsys.f ====
hdl/mem_pkg.sv
hdl/byte_lane.sv
hdl/mem_client_mux.sv
hdl/mem_if.sv
hdl/mem_subsys.sv
verif/mem_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - files:
      - hdl/mem_pkg.sv
      - hdl/byte_lane.sv
      - hdl/mem_client_mux.sv
      - hdl/mem_if.sv
      - hdl/mem_subsys.sv
  - target: test
    files:
      - verif/mem_subsys_tb.sv
